// File: hdl/ex_defines.svh
// Execution stage defines

`ifndef EX_DEFINES_SVH
`define EX_DEFINES_SVH

////////////////////////////////////////////////////////////
// Data path
////////////////////////////////////////////////////////////

// Word width, RV32 only
`define XLEN 32

////////////////////////////////////////////////////////////
// Program counter
////////////////////////////////////////////////////////////

// Reset vector
`define PC_INIT 'h200

////////////////////////////////////////////////////////////
// Divider
////////////////////////////////////////////////////////////

// One quotient bit per iteration
`define DIV_STEPS `XLEN

`endif

// File: hdl/ex_opcode_pkg.sv
// Decoded instruction types

`default_nettype none

package ex_opcode_pkg;

  ////////////////////////////////////////////////////////////
  // Operations
  ////////////////////////////////////////////////////////////

  // Execution operation, as sent by decode
  typedef enum logic [3:0] {
    ADD  = 4'h0,
    SUB  = 4'h1,
    AND  = 4'h2,
    OR   = 4'h3,
    XOR  = 4'h4,
    SLT  = 4'h5,
    SLTU = 4'h6,
    SLL  = 4'h7,
    SRL  = 4'h8,
    SRA  = 4'h9,
    // Divider operations
    DIV  = 4'ha,
    DIVU = 4'hb,
    REM  = 4'hc,
    REMU = 4'hd
  } ex_op_e;

  ////////////////////////////////////////////////////////////
  // Instruction
  ////////////////////////////////////////////////////////////

  // Destination register index
  typedef logic [4:0] reg_idx_t;

  // Decoded instruction word
  typedef struct packed {
    // Pipeline bubble, no work
    logic     bubble;
    ex_op_e   op;
    reg_idx_t rd;
    // Set by decode for DIV/DIVU/REM/REMU
    logic     is_div;
  } decoded_insn_t;

endpackage

`default_nettype wire

// File: hdl/ex_state_pkg.sv
// Execution pipeline types

`default_nettype none

`include "ex_defines.svh"

package ex_state_pkg;

  import ex_opcode_pkg::*;

  ////////////////////////////////////////////////////////////
  // Words
  ////////////////////////////////////////////////////////////

  // Data word
  typedef logic [`XLEN-1:0] xword_t;

  // Program counter
  typedef logic [`XLEN-1:0] pc_t;

  // Shift amount, low bits of operand B
  typedef logic [$clog2(`XLEN)-1:0] shamt_t;

  ////////////////////////////////////////////////////////////
  // Divider
  ////////////////////////////////////////////////////////////

  // Divider FSM
  typedef enum logic [1:0] {
    IDLE,
    RUN,
    DONE
  } div_state_e;

  // Iteration counter, counts down to zero
  typedef logic [$clog2(`DIV_STEPS)-1:0] div_cnt_t;

  ////////////////////////////////////////////////////////////
  // Stage output
  ////////////////////////////////////////////////////////////

  // Result towards the memory stage
  typedef struct packed {
    logic     bubble;
    reg_idx_t rd;
    xword_t   result;
  } ex_out_t;

endpackage

`default_nettype wire

// File: hdl/ex_alu.sv
// Integer ALU

`timescale 1ns/1ns
`default_nettype none

module ex_alu
(
  input  wire                                clk_i,
  input  wire                                rst_ni,

  // Stage stall level
  input  wire                                ex_stall_i,

  // Instruction and operands
  input  wire ex_opcode_pkg::decoded_insn_t  insn_i,
  input  wire ex_state_pkg::xword_t          opa_i,
  input  wire ex_state_pkg::xword_t          opb_i,

  // Registered result
  output ex_state_pkg::xword_t               alu_r_o,
  output logic                               alu_bubble_o
);

  import ex_opcode_pkg::*;
  import ex_state_pkg::*;

  ////////////////////////////////////////////////////////////
  // Signals
  ////////////////////////////////////////////////////////////

  shamt_t shamt;
  logic   lt_signed;
  logic   lt_unsigned;
  xword_t alu_nxt;

  ////////////////////////////////////////////////////////////
  // Compute
  ////////////////////////////////////////////////////////////

  // Shift amount from low bits of B
  assign shamt = shamt_t'(opb_i);

  // Compares
  assign lt_signed   = $signed(opa_i) < $signed(opb_i);
  assign lt_unsigned = opa_i < opb_i;

  always_comb
  begin
    unique case (insn_i.op)
      ADD     : alu_nxt = opa_i + opb_i;
      SUB     : alu_nxt = opa_i - opb_i;
      AND     : alu_nxt = opa_i & opb_i;
      OR      : alu_nxt = opa_i | opb_i;
      XOR     : alu_nxt = opa_i ^ opb_i;
      // Set-less-than gives 0 or 1
      SLT     : alu_nxt = xword_t'(lt_signed);
      SLTU    : alu_nxt = xword_t'(lt_unsigned);
      SLL     : alu_nxt = opa_i << shamt;
      SRL     : alu_nxt = opa_i >> shamt;
      // Arithmetic shift keeps the sign
      SRA     : alu_nxt = xword_t'($signed(opa_i) >>> shamt);
      // Divides are handled by the divider
      default : alu_nxt = '0;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Output registers
  ////////////////////////////////////////////////////////////

  // Bubble for input bubbles and divides
  always_ff @(posedge clk_i, negedge rst_ni)
  begin
    if (!rst_ni)
      alu_bubble_o <= 1'b1;
    else if (!ex_stall_i)
      alu_bubble_o <= insn_i.bubble | insn_i.is_div;
  end

  // Result word
  always_ff @(posedge clk_i)
  begin
    if (!ex_stall_i)
      alu_r_o <= alu_nxt;
  end

endmodule

`default_nettype wire

// File: hdl/ex_div.sv
// Iterative radix-2 divider

`timescale 1ns/1ns
`default_nettype none

`include "ex_defines.svh"

module ex_div
(
  input  wire                                clk_i,
  input  wire                                rst_ni,

  // Stage stall level
  input  wire                                ex_stall_i,

  // Instruction and operands
  input  wire ex_opcode_pkg::decoded_insn_t  insn_i,
  input  wire ex_state_pkg::xword_t          opa_i,
  input  wire ex_state_pkg::xword_t          opb_i,

  // Result, valid in DONE
  output ex_state_pkg::xword_t               div_r_o,
  output logic                               div_bubble_o,
  output logic                               div_stall_o
);

  import ex_opcode_pkg::*;
  import ex_state_pkg::*;

  ////////////////////////////////////////////////////////////
  // Signals
  ////////////////////////////////////////////////////////////

  // FSM
  div_state_e      state_q;
  div_cnt_t        cnt_q;
  logic            start_en;

  // Operand preparation
  logic            is_signed;
  logic            a_neg;
  logic            b_neg;
  logic            b_zero;
  xword_t          a_mag;
  xword_t          b_mag;

  // Shift-subtract datapath
  xword_t          rem_q;
  xword_t          quo_q;
  xword_t          dvs_q;
  logic [`XLEN:0]  rem_shift;
  logic [`XLEN:0]  rem_diff;

  // Sign fixup
  logic            neg_quo_q;
  logic            neg_rem_q;
  logic            sel_rem_q;
  xword_t          quo_fix;
  xword_t          rem_fix;

  ////////////////////////////////////////////////////////////
  // Operands
  ////////////////////////////////////////////////////////////

  // Signed variants
  assign is_signed = (insn_i.op == DIV) | (insn_i.op == REM);
  assign a_neg     = is_signed & opa_i[`XLEN-1];
  assign b_neg     = is_signed & opb_i[`XLEN-1];
  assign b_zero    = (opb_i == '0);

  // Magnitudes, most negative value maps onto itself
  assign a_mag = a_neg ? xword_t'(-opa_i) : opa_i;
  assign b_mag = b_neg ? xword_t'(-opb_i) : opb_i;

  // Accepted only outside RUN and when the stage moves
  assign start_en = ~insn_i.bubble & insn_i.is_div & ~ex_stall_i & (state_q != RUN);

  ////////////////////////////////////////////////////////////
  // FSM
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i, negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      state_q <= IDLE;
      cnt_q   <= '0;
    end
    else
    begin
      unique case (state_q)
        // DONE waits for the stage, may chain a new divide
        IDLE, DONE:
        begin
          if (start_en)
          begin
            state_q <= RUN;
            cnt_q   <= div_cnt_t'(`DIV_STEPS - 1);
          end
          else if (!ex_stall_i)
            state_q <= IDLE;
        end

        // Iterates regardless of memory back-pressure
        RUN:
        begin
          if (cnt_q == '0)
            state_q <= DONE;
          else
            cnt_q <= cnt_q - 1'b1;
        end

        default:
          state_q <= IDLE;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////////////////////////

  // Next dividend bit into partial remainder
  assign rem_shift = {rem_q, quo_q[`XLEN-1]};
  assign rem_diff  = rem_shift - {1'b0, dvs_q};

  always_ff @(posedge clk_i)
  begin
    if (start_en)
    begin
      rem_q     <= '0;
      quo_q     <= a_mag;
      dvs_q     <= b_mag;
      // Divide by zero keeps quotient all ones
      neg_quo_q <= (a_neg ^ b_neg) & ~b_zero;
      neg_rem_q <= a_neg;
      sel_rem_q <= (insn_i.op == REM) | (insn_i.op == REMU);
    end
    else if (state_q == RUN)
    begin
      // Restore on borrow
      if (rem_diff[`XLEN])
      begin
        rem_q <= rem_shift[`XLEN-1:0];
        quo_q <= {quo_q[`XLEN-2:0], 1'b0};
      end
      else
      begin
        rem_q <= rem_diff[`XLEN-1:0];
        quo_q <= {quo_q[`XLEN-2:0], 1'b1};
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Result
  ////////////////////////////////////////////////////////////

  // Remainder takes the sign of the dividend
  assign quo_fix = neg_quo_q ? xword_t'(-quo_q) : quo_q;
  assign rem_fix = neg_rem_q ? xword_t'(-rem_q) : rem_q;

  assign div_r_o      = sel_rem_q ? rem_fix : quo_fix;
  assign div_bubble_o = (state_q != DONE);
  assign div_stall_o  = (state_q == RUN);

endmodule

`default_nettype wire

// File: hdl/ex_stage.sv
// Execution stage top level

`timescale 1ns/1ns
`default_nettype none

`include "ex_defines.svh"

module ex_stage
(
  input  wire                                clk_i,
  input  wire                                rst_ni,

  // Back-pressure from memory stage
  input  wire                                mem_stall_i,

  // From decode
  input  wire ex_state_pkg::pc_t             id_pc_i,
  input  wire ex_opcode_pkg::decoded_insn_t  id_insn_i,
  input  wire ex_state_pkg::xword_t          id_opa_i,
  input  wire ex_state_pkg::xword_t          id_opb_i,
  input  wire                                id_bypa_i,
  input  wire                                id_bypb_i,

  // To memory stage
  output ex_state_pkg::pc_t                  ex_pc_o,
  output ex_state_pkg::ex_out_t              ex_out_o,
  output logic                               ex_stall_o
);

  import ex_opcode_pkg::*;
  import ex_state_pkg::*;

  ////////////////////////////////////////////////////////////
  // Signals
  ////////////////////////////////////////////////////////////

  // Bypassed operands
  xword_t   opa;
  xword_t   opb;

  // Destination of the instruction in EX
  reg_idx_t ex_rd_q;

  // Unit outputs
  xword_t   alu_r;
  logic     alu_bubble;
  xword_t   div_r;
  logic     div_bubble;
  logic     div_stall;

  ////////////////////////////////////////////////////////////
  // Operands and pipeline registers
  ////////////////////////////////////////////////////////////

  // Bypass from own last result
  assign opa = id_bypa_i ? ex_out_o.result : id_opa_i;
  assign opb = id_bypb_i ? ex_out_o.result : id_opb_i;

  // Program counter
  always_ff @(posedge clk_i, negedge rst_ni)
  begin
    if (!rst_ni)
      ex_pc_o <= pc_t'(`PC_INIT);
    else if (!ex_stall_o)
      ex_pc_o <= id_pc_i;
  end

  // Held through a divide run
  always_ff @(posedge clk_i)
  begin
    if (!ex_stall_o)
      ex_rd_q <= id_insn_i.rd;
  end

  ////////////////////////////////////////////////////////////
  // Execution units
  ////////////////////////////////////////////////////////////

  ex_alu u_alu (
    .clk_i        ( clk_i      ),
    .rst_ni       ( rst_ni     ),
    .ex_stall_i   ( ex_stall_o ),
    .insn_i       ( id_insn_i  ),
    .opa_i        ( opa        ),
    .opb_i        ( opb        ),
    .alu_r_o      ( alu_r      ),
    .alu_bubble_o ( alu_bubble )
  );

  ex_div u_div (
    .clk_i        ( clk_i      ),
    .rst_ni       ( rst_ni     ),
    .ex_stall_i   ( ex_stall_o ),
    .insn_i       ( id_insn_i  ),
    .opa_i        ( opa        ),
    .opb_i        ( opb        ),
    .div_r_o      ( div_r      ),
    .div_bubble_o ( div_bubble ),
    .div_stall_o  ( div_stall  )
  );

  ////////////////////////////////////////////////////////////
  // Merge
  ////////////////////////////////////////////////////////////

  // Divider wins when it has a result
  always_comb
  begin
    ex_out_o.bubble = alu_bubble & div_bubble;
    ex_out_o.rd     = ex_rd_q;
    ex_out_o.result = div_bubble ? alu_r : div_r;
  end

  // Shared with decode and memory stage
  assign ex_stall_o = mem_stall_i | div_stall;

endmodule

`default_nettype wire

// File: sim/ex_stage_sva.sv
// Execution stage protocol checks

`timescale 1ns/1ns
`default_nettype none

`include "ex_defines.svh"

module ex_stage_sva
(
  input  wire                          clk_i,
  input  wire                          rst_ni,

  // Stall sources and the shared stall
  input  wire                          mem_stall_i,
  input  wire                          div_stall_i,
  input  wire                          ex_stall_i,

  // Stage outputs
  input  wire ex_state_pkg::pc_t       ex_pc_i,
  input  wire ex_state_pkg::ex_out_t   ex_out_i
);

  import ex_state_pkg::*;

  // Count of failed assertions for the testbench summary
  int unsigned fail_cnt = 0;

  ////////////////////////////////////////////////////////////
  // Reset
  ////////////////////////////////////////////////////////////

  // First cycle out of reset
  reset_values_a : assert property (@(posedge clk_i)
    $rose(rst_ni) |-> ex_out_i.bubble && !ex_stall_i && (ex_pc_i == pc_t'(`PC_INIT)))
  else
  begin
    fail_cnt++;
    $error("stage outputs not at reset values after reset release");
  end

  ////////////////////////////////////////////////////////////
  // Stall behaviour
  ////////////////////////////////////////////////////////////

  // PC register frozen by any stall
  pc_hold_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    ex_stall_i |=> $stable(ex_pc_i))
  else
  begin
    fail_cnt++;
    $error("ex_pc_o changed during a stall");
  end

  // Memory back-pressure freezes the result except for a running divide
  out_hold_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (mem_stall_i && !div_stall_i) |=> $stable(ex_out_i))
  else
  begin
    fail_cnt++;
    $error("ex_out_o changed under memory back-pressure");
  end

  // Nothing leaves the stage mid-divide
  no_result_in_run_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    div_stall_i |-> ex_out_i.bubble)
  else
  begin
    fail_cnt++;
    $error("valid result presented while the divider runs");
  end

  // Divider latency bound
  div_bound_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(div_stall_i) |-> ##[1:`DIV_STEPS + 2] !div_stall_i)
  else
  begin
    fail_cnt++;
    $error("divide did not release the stall in time");
  end

endmodule

bind ex_stage ex_stage_sva sva_i (
  .clk_i       ( clk_i       ),
  .rst_ni      ( rst_ni      ),
  .mem_stall_i ( mem_stall_i ),
  .div_stall_i ( div_stall   ),
  .ex_stall_i  ( ex_stall_o  ),
  .ex_pc_i     ( ex_pc_o     ),
  .ex_out_i    ( ex_out_o    )
);

`default_nettype wire

// File: sim/ex_stage_tb.sv
// Execution stage testbench

`timescale 1ns/1ns
`default_nettype none

`include "ex_defines.svh"

module ex_stage_tb;

  import ex_opcode_pkg::*;
  import ex_state_pkg::*;

  ////////////////////////////////////////////////////////////
  // Constants and types
  ////////////////////////////////////////////////////////////

  localparam int          N_TESTS   = 5;
  localparam int          OPS       = 40;
  localparam int          TIMEOUT   = N_TESTS * OPS * (`DIV_STEPS + 2) + 500;
  localparam logic [31:0] LFSR_SEED = 32'd69214;

  // Corner operands
  localparam xword_t EDGE_VALS [8] = '{
    32'h0000_0000, 32'h0000_0001, 32'hffff_ffff, 32'h8000_0000,
    32'h7fff_ffff, 32'h0000_001f, 32'h0000_0020, 32'hffff_fffe
  };

  // One instruction held in the stage
  typedef struct packed {
    pc_t         pc;
    logic        is_div;
    logic [31:0] cycle;
    ex_out_t     out;
  } exp_t;

  // DUT ports
  logic          clk_i;
  logic          rst_ni;
  logic          mem_stall_i;
  pc_t           id_pc_i;
  decoded_insn_t id_insn_i;
  xword_t        id_opa_i;
  xword_t        id_opb_i;
  logic          id_bypa_i;
  logic          id_bypb_i;
  pc_t           ex_pc_o;
  ex_out_t       ex_out_o;
  logic          ex_stall_o;

  // Model and bookkeeping
  exp_t          exp_q [$];
  logic [31:0]   stim_lfsr;
  logic [31:0]   stall_lfsr;
  logic          stall_en     = 1'b0;
  logic [31:0]   cycle_cnt    = '0;
  int unsigned   err_cnt      = 0;
  int unsigned   check_cnt    = 0;
  int unsigned   test_cnt     = 0;
  int unsigned   accepted_cnt = 0;
  int unsigned   retired_cnt  = 0;
  pc_t           next_pc;

  ex_stage dut_i (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .mem_stall_i ( mem_stall_i ),
    .id_pc_i     ( id_pc_i     ),
    .id_insn_i   ( id_insn_i   ),
    .id_opa_i    ( id_opa_i    ),
    .id_opb_i    ( id_opb_i    ),
    .id_bypa_i   ( id_bypa_i   ),
    .id_bypb_i   ( id_bypb_i   ),
    .ex_pc_o     ( ex_pc_o     ),
    .ex_out_o    ( ex_out_o    ),
    .ex_stall_o  ( ex_stall_o  )
  );

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  // Fibonacci LFSR, taps 32 22 2 1, one step per bit
  function automatic logic [31:0] take_bits(inout logic [31:0] state, input int n);
    logic [31:0] bits;
    logic        fb;
    bits = '0;
    for (int i = 0; i < n; i++)
    begin
      fb    = state[31] ^ state[21] ^ state[1] ^ state[0];
      state = {state[30:0], fb};
      bits  = {bits[30:0], fb};
    end
    return bits;
  endfunction

  // Corner value one time in four
  function automatic xword_t pick_operand();
    if (take_bits(stim_lfsr, 2) == 0)
      return EDGE_VALS[take_bits(stim_lfsr, 3)];
    return xword_t'(take_bits(stim_lfsr, 32));
  endfunction

  // RV32 integer semantics
  function automatic xword_t ref_result(input ex_op_e op, input xword_t a, input xword_t b);
    logic signed [`XLEN-1:0] sa;
    logic signed [`XLEN-1:0] sb;
    logic        [4:0]       sh;
    logic                    ovf;
    sa  = a;
    sb  = b;
    sh  = b[4:0];
    // Most negative divided by minus one
    ovf = (a == 32'h8000_0000) && (b == '1);
    case (op)
      ADD  : return a + b;
      SUB  : return a - b;
      AND  : return a & b;
      OR   : return a | b;
      XOR  : return a ^ b;
      SLT  : return xword_t'(sa < sb);
      SLTU : return xword_t'(a < b);
      SLL  : return a << sh;
      SRL  : return a >> sh;
      SRA  : return xword_t'(sa >>> sh);
      DIV  : return (b == 0) ? '1 : (ovf ? a : xword_t'(sa / sb));
      DIVU : return (b == 0) ? '1 : a / b;
      REM  : return (b == 0) ? a : (ovf ? '0 : xword_t'(sa % sb));
      REMU : return (b == 0) ? a : a % b;
      default : return '0;
    endcase
  endfunction

  task automatic flag_error(input string msg);
    err_cnt++;
    $display("[ERROR] %0t ns: %s", $time, msg);
  endtask

  task automatic check(input logic ok, input string msg);
    check_cnt++;
    assert (ok === 1'b1) else flag_error(msg);
  endtask

  // Present one instruction, return on the edge that takes it
  task automatic issue(input ex_op_e op, input xword_t a, input xword_t b,
                       input logic bypa, input logic bypb, input logic bubble);
    decoded_insn_t insn;
    insn.bubble = bubble;
    insn.op     = op;
    insn.rd     = reg_idx_t'(take_bits(stim_lfsr, 5));
    insn.is_div = op inside {DIV, DIVU, REM, REMU};
    id_insn_i  <= insn;
    id_opa_i   <= a;
    id_opb_i   <= b;
    id_bypa_i  <= bypa;
    id_bypb_i  <= bypb;
    id_pc_i    <= next_pc;
    next_pc     = next_pc + 4;
    @(negedge clk_i);
    while (ex_stall_o)
      @(negedge clk_i);
    @(posedge clk_i);
  endtask

  // Flush with two bubbles, then compare counts
  task automatic drain();
    issue(ADD, '0, '0, 1'b0, 1'b0, 1'b1);
    issue(ADD, '0, '0, 1'b0, 1'b0, 1'b1);
    check(accepted_cnt == retired_cnt,
          $sformatf("%0d instructions accepted, %0d retired", accepted_cnt, retired_cnt));
  endtask

  task automatic report_test(input string name, input int unsigned start);
    test_cnt++;
    $display("Test %-7s finished, %0d mismatches", name, err_cnt - start);
  endtask

  ////////////////////////////////////////////////////////////
  // Reference model, checked every cycle
  ////////////////////////////////////////////////////////////

  task automatic check_cycle();
    exp_t        cur;
    exp_t        nxt;
    xword_t      opa;
    xword_t      opb;
    logic [31:0] age;
    logic        busy;
    // Empty queue is the reset state
    cur            = '0;
    cur.pc         = pc_t'(`PC_INIT);
    cur.out.bubble = 1'b1;
    if (exp_q.size() > 0)
      cur = exp_q[0];
    age  = cycle_cnt - cur.cycle;
    // Divide output due DIV_STEPS + 1 cycles after acceptance
    busy = cur.is_div && (age <= `DIV_STEPS);
    check(ex_pc_o === cur.pc, $sformatf("ex_pc_o %h, expected %h", ex_pc_o, cur.pc));
    check(ex_stall_o === (mem_stall_i | busy),
          $sformatf("ex_stall_o %b, expected %b", ex_stall_o, mem_stall_i | busy));
    if (cur.out.bubble || busy)
      check(ex_out_o.bubble === 1'b1, "valid result where a bubble is expected");
    else
      check(ex_out_o === cur.out,
            $sformatf("ex_out_o %h, expected %h", ex_out_o, cur.out));
    // Stage advances on the next edge
    if (!ex_stall_o)
    begin
      if (!ex_out_o.bubble)
        retired_cnt++;
      opa            = id_bypa_i ? cur.out.result : id_opa_i;
      opb            = id_bypb_i ? cur.out.result : id_opb_i;
      nxt.pc         = id_pc_i;
      nxt.is_div     = !id_insn_i.bubble && (id_insn_i.op inside {DIV, DIVU, REM, REMU});
      nxt.cycle      = cycle_cnt;
      nxt.out.bubble = id_insn_i.bubble;
      nxt.out.rd     = id_insn_i.rd;
      nxt.out.result = ref_result(id_insn_i.op, opa, opb);
      if (!id_insn_i.bubble)
        accepted_cnt++;
      if (exp_q.size() > 0)
        void'(exp_q.pop_front());
      exp_q.push_back(nxt);
    end
  endtask

  always @(negedge clk_i)
  begin
    if (rst_ni)
      check_cycle();
  end

  ////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////

  task automatic run_reset_test();
    int unsigned start;
    start = err_cnt;
    @(negedge clk_i);
    check(ex_out_o.bubble === 1'b1, "bubble not set after reset");
    check(ex_stall_o === 1'b0, "ex_stall_o high after reset");
    check(ex_pc_o === pc_t'(`PC_INIT), $sformatf("ex_pc_o %h after reset", ex_pc_o));
    @(posedge clk_i);
    report_test("reset", start);
  endtask

  // Each ALU op in turn
  task automatic run_alu_test();
    int unsigned start;
    xword_t      a;
    xword_t      b;
    start = err_cnt;
    for (int i = 0; i < OPS; i++)
    begin
      a = pick_operand();
      b = pick_operand();
      issue(ex_op_e'(4'(i % 10)), a, b, 1'b0, 1'b0, 1'b0);
    end
    drain();
    report_test("alu", start);
  endtask

  // Dependent chain through the bypass
  task automatic run_bypass_test();
    int unsigned start;
    logic [1:0]  sel;
    start = err_cnt;
    issue(ADD, pick_operand(), pick_operand(), 1'b0, 1'b0, 1'b0);
    for (int i = 1; i < OPS; i++)
    begin
      sel = 2'(take_bits(stim_lfsr, 2));
      if (sel == 2'b00)
        sel = 2'b01;
      issue(ex_op_e'(4'(take_bits(stim_lfsr, 4) % 10)), pick_operand(), pick_operand(),
            sel[0], sel[1], 1'b0);
    end
    drain();
    report_test("bypass", start);
  endtask

  // Divide by zero and overflow first, then random
  task automatic run_div_test();
    int unsigned start;
    ex_op_e      op;
    logic        byp;
    start = err_cnt;
    for (int k = 0; k < 4; k++)
    begin
      op = ex_op_e'(4'(DIV + k));
      issue(op, pick_operand(), '0, 1'b0, 1'b0, 1'b0);
      issue(op, 32'h8000_0000, '1, 1'b0, 1'b0, 1'b0);
    end
    for (int i = 8; i < OPS; i++)
    begin
      op  = ex_op_e'(4'(DIV + (i % 4)));
      byp = (take_bits(stim_lfsr, 2) == 0);
      issue(op, pick_operand(), pick_operand(), byp, 1'b0, 1'b0);
    end
    drain();
    report_test("div", start);
  endtask

  // Mixed traffic under random memory back-pressure
  task automatic run_stall_test();
    int unsigned start;
    logic        prev_valid;
    logic        bubble;
    logic        byp;
    ex_op_e      op;
    start      = err_cnt;
    prev_valid = 1'b0;
    stall_en  <= 1'b1;
    for (int i = 0; i < OPS; i++)
    begin
      bubble = (take_bits(stim_lfsr, 3) == 0);
      op     = ex_op_e'(4'(take_bits(stim_lfsr, 4) % 14));
      byp    = prev_valid && (take_bits(stim_lfsr, 2) == 0);
      issue(op, pick_operand(), pick_operand(), byp, 1'b0, bubble);
      prev_valid = !bubble;
    end
    stall_en <= 1'b0;
    drain();
    report_test("stall", start);
  endtask

  ////////////////////////////////////////////////////////////
  // Clock, stall source, timeout and main flow
  ////////////////////////////////////////////////////////////

  initial
  begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  // Memory back-pressure, one LFSR bit per cycle
  initial
  begin
    stall_lfsr   = LFSR_SEED;
    mem_stall_i <= 1'b0;
    forever
    begin
      @(posedge clk_i);
      mem_stall_i <= stall_en && (take_bits(stall_lfsr, 1) != 0);
    end
  end

  always @(posedge clk_i)
    cycle_cnt <= cycle_cnt + 1;

  initial
  begin
    wait (cycle_cnt >= TIMEOUT);
    $display("Timeout: run did not complete within %0d cycles", TIMEOUT);
    $display("Errors found");
    $finish;
  end

  initial
  begin
    int unsigned total;
    stim_lfsr  = LFSR_SEED;
    next_pc    = pc_t'(`PC_INIT);
    rst_ni    <= 1'b0;
    id_pc_i   <= pc_t'(`PC_INIT);
    id_insn_i <= '{bubble: 1'b1, op: ADD, rd: '0, is_div: 1'b0};
    id_opa_i  <= '0;
    id_opb_i  <= '0;
    id_bypa_i <= 1'b0;
    id_bypb_i <= 1'b0;
    repeat (2) @(posedge clk_i);
    rst_ni    <= 1'b1;
    run_reset_test();
    run_alu_test();
    run_bypass_test();
    run_div_test();
    run_stall_test();
    total = err_cnt + dut_i.sva_i.fail_cnt;
    $display("Summary: %0d tests, %0d checks, %0d mismatches, %0d assertion failures",
             test_cnt, check_cnt, err_cnt, dut_i.sva_i.fail_cnt);
    if (total == 0)
      $display("No errors");
    else
      $display("Errors found");
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+hdl
hdl/ex_opcode_pkg.sv
hdl/ex_state_pkg.sv
hdl/ex_alu.sv
hdl/ex_div.sv
hdl/ex_stage.sv
sim/ex_stage_sva.sv
sim/ex_stage_tb.sv
